// File: Bender.yml
package:
  name: asi_unit

sources:
  - hdl/asi_pkg.sv
  - hdl/aes_pkg.sv
  - hdl/asi_sha3_index.sv
  - hdl/asi_sha256_sigma.sv
  - hdl/asi_aes_sbox.sv
  - hdl/asi_aes_v1.sv
  - hdl/asi_unit.sv
  - target: test
    files:
      - verif/asi_clock_gen.sv
      - verif/asi_unit_tb.sv

// File: hdl/aes_pkg.sv
/*
 * AES package
 * Operation struct for the AES engine and the GF(2^8) arithmetic
 * used by the S-box and MixColumns
 */
package aes_pkg;

    localparam int AES_SUB_STEPS = 4;                        // SubBytes cycles, one per byte
    localparam int AES_CNT_W     = $clog2(AES_SUB_STEPS);    // Byte counter width

    typedef struct packed {
        logic dec;                                           // Inverse direction
        logic mix;                                           // MixColumns, else SubBytes
    } aes_op_t;

    // Multiply by x, reduce by x^8+x^4+x^3+x+1
    function automatic logic [7:0] xtime(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    // Shift-and-add multiply
    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] p;
        acc = 8'h00;
        p   = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) acc = acc ^ p;
            p = xtime(p);
        end
        return acc;
    endfunction

    // a^254 by repeated squaring, 0 maps to 0
    function automatic logic [7:0] gf_inv(input logic [7:0] a);
        logic [7:0] acc;
        logic [7:0] sq;
        acc = 8'h01;
        sq  = a;
        for (int i = 1; i < 8; i++) begin
            sq  = gf_mul(sq, sq);                            // a^(2^i)
            acc = gf_mul(acc, sq);
        end
        return acc;
    endfunction

    function automatic logic [7:0] affine_fwd(input logic [7:0] a);
        return a ^ {a[6:0], a[7]} ^ {a[5:0], a[7:6]} ^ {a[4:0], a[7:5]}
                 ^ {a[3:0], a[7:4]} ^ 8'h63;
    endfunction

    function automatic logic [7:0] affine_inv(input logic [7:0] a);
        return {a[6:0], a[7]} ^ {a[4:0], a[7:5]} ^ {a[1:0], a[7:2]} ^ 8'h05;
    endfunction

endpackage

// File: hdl/asi_aes_sbox.sv
/*
 * AES S-box
 * Forward and inverse byte substitution from one shared GF(2^8)
 * inverter and the two affine maps, no lookup table
 */
module asi_aes_sbox import aes_pkg::*; (
    input  logic [7:0] din,                 // Byte in
    input  logic       dec,                 // Inverse S-box
    output logic [7:0] dout                 // Substituted byte
);

    // --------------------
    // Inverse path front
    // --------------------
    // InvSubBytes undoes the affine map before inverting, so the
    // inverse affine sits in front of the shared inverter
    logic [7:0] pre_aff;                    // Inverse affine of din
    logic [7:0] inv_in;                     // Inverter operand

    assign pre_aff = affine_inv(din);
    assign inv_in  = dec ? pre_aff : din;   // Forward feeds din straight in

    // --------------------
    // Shared inverter
    // --------------------
    logic [7:0] inv_out;                    // Multiplicative inverse

    assign inv_out = gf_inv(inv_in);        // 0 stays 0

    // --------------------
    // Forward path back
    // --------------------
    logic [7:0] post_aff;                   // Forward affine of inverse

    assign post_aff = affine_fwd(inv_out);

    // Inverse result is the bare inverse
    assign dout = dec ? inv_out : post_aff;

endmodule

// File: hdl/asi_aes_v1.sv
/*
 * AES engine, simple variant
 * SubBytes or InvSubBytes of a word over four cycles through one S-box,
 * and single-cycle MixColumns or InvMixColumns of one column
 */
module asi_aes_v1 import asi_pkg::*, aes_pkg::*; (
    input  logic            g_clk,
    input  logic            rst,
    input  logic            valid,          // Held until ready
    input  logic            flush,          // Abandon SubBytes in progress
    input  aes_op_t         op,             // Direction and sub or mix
    input  logic [XLEN-1:0] rs1,            // Column, byte 0 is row 0
    output logic            ready,          // Result available
    output logic [XLEN-1:0] rd              // Result word
);

    logic [3:0][7:0]                   col_in;        // rs1 as four bytes
    logic [AES_CNT_W-1:0]              sub_cnt;       // Byte being substituted
    logic [8*(AES_SUB_STEPS-1)-1:0]    sub_hold;      // Finished bytes 0 to 2
    logic                              sub_valid;
    logic                              sub_last;      // Byte 3 this cycle
    logic                              sub_done;
    logic                              mix_valid;
    logic [7:0]                        sbox_out;
    logic [XLEN-1:0]                   sub_word;
    logic [3:0][7:0]                   mix_enc;
    logic [3:0][7:0]                   mix_dec;
    logic [XLEN-1:0]                   mix_word;

    assign col_in    = rs1;
    assign sub_valid = valid && !op.mix;
    assign mix_valid = valid && op.mix;
    assign sub_last  = sub_cnt == AES_CNT_W'(AES_SUB_STEPS - 1);
    assign sub_done  = sub_valid && sub_last;

    // --------------------
    // SubBytes
    // --------------------
    asi_aes_sbox u_sbox (
        .din  (col_in[sub_cnt]),            // One byte per cycle
        .dec  (op.dec),
        .dout (sbox_out)
    );

    always_ff @(posedge g_clk) begin
        if (rst || flush) begin
            sub_cnt <= '0;
        end else if (sub_valid) begin
            sub_cnt <= sub_last ? '0 : sub_cnt + 1'b1;  // Wrap for back-to-back
        end
    end

    always_ff @(posedge g_clk) begin
        if (sub_valid && !sub_last) begin
            sub_hold[8*sub_cnt +: 8] <= sbox_out;       // Store finished byte
        end
    end

    assign sub_word = {sbox_out, sub_hold};             // Byte 3 still combinational

    // --------------------
    // MixColumns
    // --------------------
    always_comb begin
        for (int r = 0; r < 4; r++) begin
            mix_enc[r] = xtime(col_in[r]) ^ xtime(col_in[(r+1)%4]) ^ col_in[(r+1)%4]
                       ^ col_in[(r+2)%4] ^ col_in[(r+3)%4];
            mix_dec[r] = gf_mul(col_in[r], 8'h0e) ^ gf_mul(col_in[(r+1)%4], 8'h0b)
                       ^ gf_mul(col_in[(r+2)%4], 8'h0d) ^ gf_mul(col_in[(r+3)%4], 8'h09);
        end
    end

    assign mix_word = op.dec ? mix_dec : mix_enc;

    assign ready = mix_valid || sub_done;               // Mix answers at once
    assign rd    = ({XLEN{mix_valid}} & mix_word) |
                   ({XLEN{sub_done}}  & sub_word);

endmodule

// File: hdl/asi_pkg.sv
/*
 * Algorithm-specific instruction package
 * Word width, micro-op class and function encodings, and the request
 * struct that carries one instruction into the unit
 */
package asi_pkg;

    // --------------------
    // Sizes
    // --------------------
    localparam int XLEN        = 32;                 // Data word width
    localparam int ASI_UOP_W   = 5;                  // Micro-op width
    localparam int ASI_CLASS_W = 2;                  // Class field, top of uop

    // Instruction class, top two bits of the micro-op
    typedef enum logic [ASI_CLASS_W-1:0] {
        ASI_NONE = 2'b00,                            // No ASI instruction
        ASI_AES  = 2'b01,                            // AES sub and mix
        ASI_SHA2 = 2'b10,                            // SHA-256 sigmas
        ASI_SHA3 = 2'b11                             // Keccak lane indexing
    } asi_class_e;

    // Full micro-op, class then 3-bit function
    typedef enum logic [ASI_UOP_W-1:0] {
        ASI_SHA256_S0 = {ASI_SHA2, 3'b000},          // Small sigma0
        ASI_SHA256_S1 = {ASI_SHA2, 3'b001},          // Small sigma1
        ASI_SHA256_S2 = {ASI_SHA2, 3'b010},          // Big Sigma0
        ASI_SHA256_S3 = {ASI_SHA2, 3'b011},          // Big Sigma1
        ASI_SHA3_XY   = {ASI_SHA3, 3'b000},          // x + 5y
        ASI_SHA3_X1   = {ASI_SHA3, 3'b001},          // (x+1) + 5y
        ASI_SHA3_X2   = {ASI_SHA3, 3'b010},          // (x+2) + 5y
        ASI_SHA3_X4   = {ASI_SHA3, 3'b011},          // (x+4) + 5y
        ASI_SHA3_YX   = {ASI_SHA3, 3'b100},          // y + 5(2x+3y)
        ASI_AES_ENCS  = {ASI_AES,  3'b000},          // SubBytes
        ASI_AES_DECS  = {ASI_AES,  3'b001},          // InvSubBytes
        ASI_AES_ENCM  = {ASI_AES,  3'b010},          // MixColumns
        ASI_AES_DECM  = {ASI_AES,  3'b011}           // InvMixColumns
    } asi_uop_e;

    // --------------------
    // Request
    // --------------------
    typedef struct packed {
        logic [ASI_UOP_W-1:0] uop;                   // Operation to perform
        logic [XLEN-1:0]      rs1;                   // Source register 1
        logic [XLEN-1:0]      rs2;                   // Source register 2
        logic [1:0]           shamt;                 // SHA3 post-shift
    } asi_req_t;

endpackage

// File: hdl/asi_sha256_sigma.sv
/*
 * SHA-256 sigma
 * The two small and two big sigma transforms of one word
 */
module asi_sha256_sigma import asi_pkg::*; (
    input  logic [XLEN-1:0] rs1,            // Gated source word
    input  logic [1:0]      ss,             // Sigma select
    output logic [XLEN-1:0] result
);

    function automatic logic [XLEN-1:0] ror(input logic [XLEN-1:0] x, input int n);
        return (x >> n) | (x << (XLEN - n));
    endfunction

    logic [XLEN-1:0] s0;                    // Small sigma0
    logic [XLEN-1:0] s1;                    // Small sigma1
    logic [XLEN-1:0] s2;                    // Big Sigma0
    logic [XLEN-1:0] s3;                    // Big Sigma1

    assign s0 = ror(rs1, 7)  ^ ror(rs1, 18) ^ (rs1 >> 3);
    assign s1 = ror(rs1, 17) ^ ror(rs1, 19) ^ (rs1 >> 10);
    assign s2 = ror(rs1, 2)  ^ ror(rs1, 13) ^ ror(rs1, 22);
    assign s3 = ror(rs1, 6)  ^ ror(rs1, 11) ^ ror(rs1, 25);

    always_comb begin
        case (ss)
            2'd0:    result = s0;
            2'd1:    result = s1;
            2'd2:    result = s2;
            default: result = s3;
        endcase
    end

endmodule

// File: hdl/asi_sha3_index.sv
/*
 * SHA3 lane index
 * Keccak lane-index functions of two coordinates, with a post-shift
 */
module asi_sha3_index import asi_pkg::*; (
    input  logic [XLEN-1:0] rs1,            // x in [2:0]
    input  logic [XLEN-1:0] rs2,            // y in [2:0]
    input  logic [1:0]      shamt,          // Post-shift amount
    input  logic            f_xy,           // One-hot function strobes
    input  logic            f_x1,
    input  logic            f_x2,
    input  logic            f_x4,
    input  logic            f_yx,
    output logic [XLEN-1:0] result
);

    logic [5:0] x_w;                        // Coordinates widened
    logic [5:0] y_w;
    logic [5:0] y_x5;                       // 5y
    logic [5:0] idx_xy;
    logic [5:0] idx_x1;
    logic [5:0] idx_x2;
    logic [5:0] idx_x4;
    logic [5:0] idx_yx;
    logic [5:0] idx_sel;

    function automatic logic [2:0] mod5(input logic [5:0] v);
        return 3'(v % 6'd5);
    endfunction

    assign x_w  = {3'b000, rs1[2:0]};
    assign y_w  = {3'b000, rs2[2:0]};
    assign y_x5 = 6'(y_w * 6'd5);           // At most 35

    assign idx_xy = {3'b000, mod5(x_w)}          + y_x5;
    assign idx_x1 = {3'b000, mod5(x_w + 6'd1)}   + y_x5;
    assign idx_x2 = {3'b000, mod5(x_w + 6'd2)}   + y_x5;
    assign idx_x4 = {3'b000, mod5(x_w + 6'd4)}   + y_x5;
    assign idx_yx = y_w + 6'(mod5(6'((x_w << 1) + y_w * 6'd3)) * 6'd5);

    // AND-OR select, zero with no strobe
    assign idx_sel = ({6{f_xy}} & idx_xy) | ({6{f_x1}} & idx_x1) |
                     ({6{f_x2}} & idx_x2) | ({6{f_x4}} & idx_x4) |
                     ({6{f_yx}} & idx_yx);

    assign result = {{(XLEN-6){1'b0}}, idx_sel} << shamt;

endmodule

// File: hdl/asi_unit.sv
/*
 * Algorithm-specific instruction unit
 * Decodes AES, SHA2 and SHA3 micro-ops, runs the matching engine and
 * returns the selected result under a valid/ready handshake
 */
module asi_unit import asi_pkg::*, aes_pkg::*; (
    input  logic            g_clk,
    input  logic            rst,
    input  logic            valid,          // Held with req until ready
    input  logic            flush,          // Abandon multi-cycle AES
    input  asi_req_t        req,            // Instruction and operands
    output logic            ready,          // Instruction completes
    output logic [XLEN-1:0] result
);

    // --------------------
    // Decode
    // --------------------
    asi_class_e      uop_class;
    logic            insn_aes;
    logic            insn_sha2;
    logic            insn_sha3;
    logic [XLEN-1:0] sha2_rs1;              // Zero outside SHA2
    aes_op_t         aes_op;
    logic            aes_ready;
    logic [XLEN-1:0] result_aes;
    logic [XLEN-1:0] result_sha2;
    logic [XLEN-1:0] result_sha3;

    assign uop_class = asi_class_e'(req.uop[ASI_UOP_W-1 -: ASI_CLASS_W]);
    assign insn_aes  = valid && (uop_class == ASI_AES);
    assign insn_sha2 = valid && (uop_class == ASI_SHA2);
    assign insn_sha3 = valid && (uop_class == ASI_SHA3);

    assign sha2_rs1 = {XLEN{insn_sha2}} & req.rs1;      // Keeps sigma logic quiet
    assign aes_op   = '{dec: (req.uop == ASI_AES_DECS) || (req.uop == ASI_AES_DECM),
                        mix: (req.uop == ASI_AES_ENCM) || (req.uop == ASI_AES_DECM)};

    // --------------------
    // Engines
    // --------------------
    asi_sha3_index u_sha3_index (
        .rs1    (req.rs1),
        .rs2    (req.rs2),
        .shamt  (req.shamt),
        .f_xy   (valid && (req.uop == ASI_SHA3_XY)),
        .f_x1   (valid && (req.uop == ASI_SHA3_X1)),
        .f_x2   (valid && (req.uop == ASI_SHA3_X2)),
        .f_x4   (valid && (req.uop == ASI_SHA3_X4)),
        .f_yx   (valid && (req.uop == ASI_SHA3_YX)),
        .result (result_sha3)
    );

    asi_sha256_sigma u_sha256_sigma (
        .rs1    (sha2_rs1),
        .ss     (req.uop[1:0]),             // Low bits pick the sigma
        .result (result_sha2)
    );

    asi_aes_v1 u_aes_v1 (
        .g_clk  (g_clk),
        .rst    (rst),
        .valid  (insn_aes),
        .flush  (flush),
        .op     (aes_op),
        .rs1    (req.rs1),
        .ready  (aes_ready),
        .rd     (result_aes)
    );

    // Result select and handshake
    assign result = ({XLEN{insn_aes}}  & result_aes)  |
                    ({XLEN{insn_sha2}} & result_sha2) |
                    ({XLEN{insn_sha3}} & result_sha3);
    assign ready  = insn_sha2 || insn_sha3 || (insn_aes && aes_ready);

endmodule

// File: sim.f
hdl/asi_pkg.sv
hdl/aes_pkg.sv
hdl/asi_sha3_index.sv
hdl/asi_sha256_sigma.sv
hdl/asi_aes_sbox.sv
hdl/asi_aes_v1.sv
hdl/asi_unit.sv
verif/asi_clock_gen.sv
verif/asi_unit_tb.sv

// File: verif/asi_clock_gen.sv
/*
 * Testbench clock and reset
 * 8 ns clock, reset held high for the first four cycles
 */
module asi_clock_gen (
    output logic g_clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD = 4;         // 8 ns period
    localparam int RST_CYCLES  = 4;

    initial begin
        g_clk = 1'b0;
        forever #HALF_PERIOD g_clk = ~g_clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge g_clk);
        rst <= 1'b0;                        // Release on a rising edge
    end

endmodule

// File: verif/asi_unit_tb.sv
/*
 * Testbench for the ASI unit
 * Drives SHA2, SHA3 and AES requests under the valid/ready handshake,
 * concurrent assertions compare against the models below
 */
module asi_unit_tb import asi_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_CYCLES = 2000;       // ~320 requests, SubBytes 4 cycles each, margin
    localparam int SEED       = 85525;

    logic            g_clk;
    logic            rst;
    logic            valid;
    logic            flush;
    asi_req_t        req;
    logic            ready;
    logic [XLEN-1:0] result;

    logic [XLEN-1:0] exp_res;               // Model result of current request
    logic            chk_res;               // Result known in advance
    int              exp_lat;               // Valid cycles before ready
    string           test_name;
    int              vcyc;                  // Position inside current request
    logic            done_q;                // Completed on last rising edge
    logic [XLEN-1:0] last_res;              // Result of last completed request
    int              errors;
    int              n_req;
    int              wd_cyc;

    asi_uop_e sha2_ops[4] = '{ASI_SHA256_S0, ASI_SHA256_S1, ASI_SHA256_S2, ASI_SHA256_S3};
    asi_uop_e sha3_ops[5] = '{ASI_SHA3_XY, ASI_SHA3_X1, ASI_SHA3_X2, ASI_SHA3_X4, ASI_SHA3_YX};

    asi_clock_gen u_clock_gen (.g_clk(g_clk), .rst(rst));

    asi_unit u_asi_unit (
        .g_clk  (g_clk),
        .rst    (rst),
        .valid  (valid),
        .flush  (flush),
        .req    (req),
        .ready  (ready),
        .result (result)
    );

    // --------------------
    // Reference models
    // --------------------
    function automatic logic [XLEN-1:0] rotr(input logic [XLEN-1:0] x, input int n);
        logic [2*XLEN-1:0] dbl;
        dbl = {x, x} >> n;                  // Low half holds the rotation
        return dbl[XLEN-1:0];
    endfunction

    function automatic logic [XLEN-1:0] sigma_model(input int sel, input logic [XLEN-1:0] x);
        case (sel)
            0:       return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
            1:       return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
            2:       return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
            default: return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
        endcase
    endfunction

    function automatic logic [XLEN-1:0] index_model(input int fn, input int x, input int y,
                                                    input int sh);
        int idx;
        case (fn)
            0:       idx = x % 5 + 5 * y;
            1:       idx = (x + 1) % 5 + 5 * y;
            2:       idx = (x + 2) % 5 + 5 * y;
            3:       idx = (x + 4) % 5 + 5 * y;
            default: idx = y + 5 * ((2 * x + 3 * y) % 5);
        endcase
        return XLEN'(idx << sh);
    endfunction

    // --------------------
    // Checks
    // --------------------
    always @(posedge g_clk) begin
        vcyc   <= (rst || !valid || ready) ? 0 : vcyc + 1;
        done_q <= valid && ready;
        if (valid && ready) last_res <= result;
    end

    a_result: assert property (@(posedge g_clk) disable iff (rst)
        valid && ready && chk_res |-> result == exp_res)
        else begin
            errors++;
            $display("MISMATCH %s expected %h actual %h", test_name, exp_res, $sampled(result));
        end

    a_latency: assert property (@(posedge g_clk) disable iff (rst)
        valid |-> ready == (vcyc == exp_lat))
        else begin
            errors++;
            $display("MISMATCH %s ready in valid cycle %0d expected %b actual %b", test_name,
                     $sampled(vcyc), $sampled(vcyc) == exp_lat, $sampled(ready));
        end

    a_idle: assert property (@(posedge g_clk) !valid |-> !ready && result == '0)
        else begin
            errors++;
            $display("MISMATCH idle expected ready 0 result 0 actual ready %b result %h",
                     $sampled(ready), $sampled(result));
        end

    // --------------------
    // Stimulus
    // --------------------
    // Called on a falling edge, returns on the falling edge after completion
    task automatic run_req(input asi_uop_e uop, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b, input logic [1:0] sh,
                           input logic [XLEN-1:0] exp, input logic chk, input int lat,
                           input string name);
        valid     = 1'b1;
        req       = '{uop: uop, rs1: a, rs2: b, shamt: sh};
        exp_res   = exp;
        chk_res   = chk;
        exp_lat   = lat;
        test_name = name;
        do @(negedge g_clk); while (!done_q);
        valid = 1'b0;
        n_req++;
    endtask

    initial begin
        logic [XLEN-1:0] w;
        logic [1:0]      sh;
        void'($urandom(SEED));
        valid     = 1'b0;
        flush     = 1'b0;
        req       = '0;
        exp_res   = '0;
        chk_res   = 1'b0;
        exp_lat   = 0;
        test_name = "reset";
        errors    = 0;
        n_req     = 0;
        @(negedge g_clk iff !rst);
        repeat (2) @(negedge g_clk);        // Idle after reset
        for (int s = 0; s < 4; s++) begin
            for (int i = 0; i < 40; i++) begin
                w = $urandom;
                run_req(sha2_ops[s], w, $urandom, 2'($urandom), sigma_model(s, w), 1'b1, 0,
                        "sha256_sigma");
            end
        end
        for (int f = 0; f < 5; f++) begin
            for (int x = 0; x < 5; x++) begin
                for (int y = 0; y < 5; y++) begin
                    sh = 2'($urandom);      // Upper operand bits are noise
                    run_req(sha3_ops[f], ($urandom & ~32'h7) | XLEN'(x),
                            ($urandom & ~32'h7) | XLEN'(y), sh, index_model(f, x, y, sh),
                            1'b1, 0, "sha3_index");
                end
            end
        end
        repeat (2) @(negedge g_clk);
        run_req(ASI_AES_ENCS, '0, '0, '0, 32'h63636363, 1'b1, 3, "aes_sub_zero");
        for (int i = 0; i < 8; i++) begin
            w = $urandom;
            run_req(ASI_AES_ENCS, w, $urandom, '0, '0, 1'b0, 3, "aes_sub_fwd");
            run_req(ASI_AES_DECS, last_res, $urandom, '0, w, 1'b1, 3, "aes_sub_round_trip");
        end
        run_req(ASI_AES_ENCM, 32'h455313db, '0, '0, 32'hbca14d8e, 1'b1, 0, "aes_mix_known");
        for (int i = 0; i < 8; i++) begin
            w = $urandom;
            run_req(ASI_AES_ENCM, w, $urandom, '0, '0, 1'b0, 0, "aes_mix_fwd");
            run_req(ASI_AES_DECM, last_res, $urandom, '0, w, 1'b1, 0, "aes_mix_round_trip");
        end
        // SubBytes abandoned in its 2nd cycle, valid dropped with the flush
        test_name = "aes_flush";
        chk_res   = 1'b0;
        exp_lat   = 3;
        valid     = 1'b1;
        req       = '{uop: ASI_AES_ENCS, rs1: $urandom, rs2: '0, shamt: '0};
        @(negedge g_clk);
        valid = 1'b0;
        flush = 1'b1;
        @(negedge g_clk);
        flush = 1'b0;
        run_req(ASI_AES_ENCS, 32'h01531000, '0, '0, 32'h7cedca63, 1'b1, 3, "aes_sub_after_flush");
        repeat (4) @(negedge g_clk);
        $display("Requests %0d, errors %0d", n_req, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wd_cyc = 0;
        while (wd_cyc < MAX_CYCLES) begin
            @(posedge g_clk);
            wd_cyc++;
        end
        $display("Run timed out after %0d cycles, a request never completed", wd_cyc);
        $display("Result: FAILED");
        $finish;
    end

endmodule
